// File: sim.f
+incdir+logic
logic/rename_pkg.sv
logic/inst_decode.sv
logic/map_table.sv
logic/free_list.sv
logic/rename_output_stage.sv
logic/rename_top.sv
verif/rename_tb.sv

// File: Makefile
TOP = rename_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

# a $fatal in the testbench gives a non-zero exit status
sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// File: verif/rename_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module rename_tb;

	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam int LIMIT = 300;

	logic clock;
	logic reset;
	logic in_valid;
	logic [31:0] in_instr;
	logic in_ready;
	logic out_valid;
	logic out_write;
	rename_pkg::phys_reg_t out_pdest;
	rename_pkg::phys_reg_t out_psrc1;
	rename_pkg::phys_reg_t out_psrc2;
	rename_pkg::phys_reg_t out_told;
	logic out_ready;
	logic retire_valid;
	rename_pkg::phys_reg_t retire_reg;
	logic checkpoint_save;
	logic checkpoint_restore;

	// reference model state
	rename_pkg::phys_reg_t model_map [`RENAME_NUM_ARCH_REG];
	rename_pkg::phys_reg_t ckpt_map [`RENAME_NUM_ARCH_REG];
	rename_pkg::phys_reg_t free_q [$];
	// registers handed out since the last save, given back by a restore
	rename_pkg::phys_reg_t popped_q [$];
	// expected items as {write, pdest, psrc1, psrc2, told}
	logic [24:0] exp_q [$];
	logic spec_q [$];
	// told registers of committed items, waiting for retire
	rename_pkg::phys_reg_t retire_pool [$];
	logic speculating;
	logic stall;
	logic random_ready;
	logic retire_enable;
	int seed;

	rename_top uut (.*);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic abort(input string line);
		$display("%s", line);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_field(input string name, input logic [5:0] got, input logic [5:0] exp);
		assert (got == exp)
		else abort($sformatf("[ERROR] %0t %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	// store, branch and rd=x0 leave the map alone
	function automatic logic writes_rd(input logic [31:0] instr);
		return (instr[6:0] != 7'b0100011) && (instr[6:0] != 7'b1100011)
			&& (instr[11:7] != 5'd0);
	endfunction

	function automatic void rename_expect(input logic [31:0] instr);
		logic wr;
		rename_pkg::phys_reg_t pdest;
		rename_pkg::phys_reg_t told;
		wr = writes_rd(instr);
		pdest = '0;
		told = '0;
		if (wr) begin
			pdest = free_q.pop_front();
			told = model_map[instr[11:7]];
			popped_q.push_back(pdest);
		end
		// sources see the mapping from before this instruction
		exp_q.push_back({wr, pdest, model_map[instr[19:15]], model_map[instr[24:20]], told});
		spec_q.push_back(speculating);
		if (wr) model_map[instr[11:7]] = pdest;
	endfunction

	// random rd is forced off x0 so a register is always taken
	function automatic logic [31:0] write_instr();
		logic [31:0] r;
		r = $random(seed);
		return {7'b0, r[24:15], 3'b0, (r[11:7] == 5'd0) ? 5'd1 : r[11:7], OPC_OP};
	endfunction

	// caller sits at a falling edge
	task automatic wait_accept();
		int t;
		t = 0;
		while (!in_ready) begin
			t++;
			if (t > LIMIT) abort("timed out waiting for the DUT to accept an instruction");
			else @(negedge clock);
		end
	endtask

	task automatic send(input logic [31:0] instr);
		@(posedge clock);
		in_valid <= 1'b1;
		in_instr <= instr;
		@(negedge clock);
		wait_accept();
	endtask

	task automatic wait_drain();
		int t;
		t = 0;
		@(posedge clock);
		in_valid <= 1'b0;
		while (exp_q.size() != 0) begin
			t++;
			if (t > LIMIT) abort("timed out waiting for the output stream to drain");
			else @(posedge clock);
		end
		@(negedge clock);
	endtask

	// model and comparison, at falling edges where everything is stable
	// what is seen here takes effect at the next rising edge
	initial begin : track
		logic [24:0] item;
		logic [24:0] held;
		logic stalled;
		logic restored;
		stalled = 1'b0;
		restored = 1'b0;
		speculating = 1'b0;
		// reset state, arch i on phys i and phys 32..63 free in order
		for (int i = 0; i < `RENAME_NUM_ARCH_REG; i++) begin
			model_map[i] = rename_pkg::phys_reg_t'(i);
			ckpt_map[i] = rename_pkg::phys_reg_t'(i);
		end
		for (int i = 0; i < `RENAME_FL_SIZE; i++) begin
			free_q.push_back(rename_pkg::phys_reg_t'(`RENAME_NUM_ARCH_REG + i));
		end
		forever begin
			@(negedge clock);
			if (!reset) begin
				if (restored) begin
					assert (!out_valid) else abort("out_valid stayed high after a restore");
				end else if (stalled) begin
					assert (out_valid && held == {out_write, out_pdest, out_psrc1, out_psrc2, out_told})
					else abort($sformatf("[ERROR] %0t outputs changed while stalled", $time));
				end
				stalled = out_valid && !out_ready;
				held = {out_write, out_pdest, out_psrc1, out_psrc2, out_told};
				if (out_valid && out_ready) begin
					assert (exp_q.size() != 0) else abort("DUT sent an item that was never expected");
					item = exp_q.pop_front();
					check_field("out_write", {5'b0, out_write}, {5'b0, item[24]});
					check_field("out_pdest", out_pdest, item[23:18]);
					check_field("out_psrc1", out_psrc1, item[17:12]);
					check_field("out_psrc2", out_psrc2, item[11:6]);
					check_field("out_told", out_told, item[5:0]);
					// told of a renamed-after-save item is mapped again after restore
					if (!spec_q.pop_front() && item[24]) retire_pool.push_back(item[5:0]);
				end
				if (in_valid && writes_rd(in_instr) && free_q.size() == 0) begin
					assert (!in_ready) else abort("in_ready high with no free physical register");
				end
				if (checkpoint_restore) begin
					assert (!in_ready) else abort("in_ready high during a restore");
					model_map = ckpt_map;
					free_q = {popped_q, free_q};
					popped_q.delete();
					exp_q.delete();
					spec_q.delete();
					speculating = 1'b0;
				end else begin
					if (in_valid && in_ready) rename_expect(in_instr);
					if (checkpoint_save) begin
						ckpt_map = model_map;
						popped_q.delete();
						speculating = 1'b1;
					end
				end
				if (retire_valid) free_q.push_back(retire_reg);
				restored = checkpoint_restore;
			end
		end
	end

	// out_ready and retire pulses
	initial begin : side_drive
		logic [31:0] r;
		out_ready = 1'b1;
		retire_valid = 1'b0;
		retire_reg = '0;
		forever begin
			@(posedge clock);
			r = $random(seed);
			if (stall) out_ready <= 1'b0;
			else if (random_ready) out_ready <= r[0];
			else out_ready <= 1'b1;
			// retire roughly one cycle in four
			if (retire_enable && retire_pool.size() != 0 && r[3:2] == 2'd0) begin
				retire_valid <= 1'b1;
				retire_reg <= retire_pool.pop_front();
			end else begin
				retire_valid <= 1'b0;
			end
		end
	end

	initial begin : main
		logic [31:0] w;
		int n;
		seed = 32'h8302;
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		checkpoint_save = 1'b0;
		checkpoint_restore = 1'b0;
		stall = 1'b0;
		random_ready = 1'b0;
		retire_enable = 1'b0;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		// dependent chain, then store, branch and rd=x0 between writes
		send({7'b0, 5'd3, 5'd2, 3'b0, 5'd1, OPC_OP});
		send({7'b0, 5'd1, 5'd1, 3'b0, 5'd2, OPC_OP});
		send({7'b0, 5'd2, 5'd1, 3'b0, 5'd1, OPC_OP});
		send({7'b0, 5'd1, 5'd2, 3'b010, 5'd4, 7'b0100011});
		send({7'b0, 5'd2, 5'd1, 3'b0, 5'd8, 7'b1100011});
		send({7'b0, 5'd2, 5'd1, 3'b0, 5'd0, OPC_OP});
		send({7'b0, 5'd2, 5'd2, 3'b0, 5'd5, OPC_OP});
		wait_drain();
		// use up the free list, then a retire lets the blocked write through
		n = free_q.size();
		repeat (n) send(write_instr());
		w = write_instr();
		@(posedge clock);
		in_instr <= w;
		repeat (8) @(negedge clock);
		retire_enable = 1'b1;
		wait_accept();
		// random back-pressure, mixed instructions and input gaps
		random_ready = 1'b1;
		repeat (300) begin
			w = $random(seed);
			if (w[0]) w = write_instr();
			else if (w[1]) w[6:0] = 7'b0100011;
			else if (w[2]) w[6:0] = 7'b1100011;
			send(w);
		end
		wait_drain();
		random_ready = 1'b0;
		// save, speculative renames, then restore
		for (int k = 0; k < 8; k++) begin
			w = write_instr();
			n = 1 + int'(w[16:15]);
			send(write_instr());
			send(write_instr());
			wait_drain();
			@(posedge clock);
			checkpoint_save <= 1'b1;
			@(posedge clock);
			checkpoint_save <= 1'b0;
			@(negedge clock);
			repeat (n) send(write_instr());
			// odd rounds hold the last item in flight so out_valid must drop
			// even rounds keep the output moving so only the restore blocks in_ready
			stall = k[0];
			w = write_instr();
			@(posedge clock);
			in_instr <= w;
			@(posedge clock);
			checkpoint_restore <= 1'b1;
			@(posedge clock);
			checkpoint_restore <= 1'b0;
			@(negedge clock);
			stall = 1'b0;
			wait_accept();
		end
		// cycle through the list so retires made under speculation get used
		repeat (64) send(write_instr());
		wait_drain();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/rename_top.sv
`default_nettype none
`timescale 1ns/1ns

module rename_top (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input logic [31:0] in_instr,
	output logic in_ready,
	output logic out_valid,
	output logic out_write,
	output rename_pkg::phys_reg_t out_pdest,
	output rename_pkg::phys_reg_t out_psrc1,
	output rename_pkg::phys_reg_t out_psrc2,
	output rename_pkg::phys_reg_t out_told,
	input logic out_ready,
	input logic retire_valid,
	input rename_pkg::phys_reg_t retire_reg,
	input logic checkpoint_save,
	input logic checkpoint_restore
);

	// decoded fields of the instruction on the input stream
	rename_pkg::arch_reg_t rd;
	rename_pkg::arch_reg_t rs1;
	rename_pkg::arch_reg_t rs2;
	logic write;

	// map lookups and free list head
	rename_pkg::phys_reg_t psrc1;
	rename_pkg::phys_reg_t psrc2;
	rename_pkg::phys_reg_t told;
	rename_pkg::phys_reg_t free_reg;
	logic empty;
	logic alloc;

	inst_decode u_decode (
		.instr(in_instr),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.write(write)
	);

	map_table u_map (
		.clock(clock),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.alloc(alloc),
		.new_reg(free_reg),
		.save(checkpoint_save),
		.restore(checkpoint_restore),
		.psrc1(psrc1),
		.psrc2(psrc2),
		.told(told)
	);

	// retired told registers go straight back to the tail
	free_list u_free (
		.clock(clock),
		.reset(reset),
		.pop(alloc),
		.push(retire_valid),
		.push_reg(retire_reg),
		.save(checkpoint_save),
		.restore(checkpoint_restore),
		.free_reg(free_reg),
		.empty(empty)
	);

	rename_output_stage u_out (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.write(write),
		.empty(empty),
		.restore(checkpoint_restore),
		.pdest(free_reg),
		.psrc1(psrc1),
		.psrc2(psrc2),
		.told(told),
		.alloc(alloc),
		.out_valid(out_valid),
		.out_write(out_write),
		.out_pdest(out_pdest),
		.out_psrc1(out_psrc1),
		.out_psrc2(out_psrc2),
		.out_told(out_told),
		.out_ready(out_ready)
	);

endmodule

`default_nettype wire

// File: logic/rename_output_stage.sv
`default_nettype none
`timescale 1ns/1ns

module rename_output_stage (
	input logic clock,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input logic write,
	input logic empty,
	input logic restore,
	input rename_pkg::phys_reg_t pdest,
	input rename_pkg::phys_reg_t psrc1,
	input rename_pkg::phys_reg_t psrc2,
	input rename_pkg::phys_reg_t told,
	output logic alloc,
	output logic out_valid,
	output logic out_write,
	output rename_pkg::phys_reg_t out_pdest,
	output rename_pkg::phys_reg_t out_psrc1,
	output rename_pkg::phys_reg_t out_psrc2,
	output rename_pkg::phys_reg_t out_told,
	input logic out_ready
);

	logic slot_free;
	logic accept;

	// output register is empty or its item leaves at this edge
	assign slot_free = !out_valid || out_ready;

	// a writing instruction waits while no physical register is free
	// nothing is taken during a restore, the map is being rolled back
	assign in_ready = slot_free && !restore && (!write || !empty);

	assign accept = in_valid && in_ready;

	// free list pop and map write happen together on this
	assign alloc = accept && write;

	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (restore) begin
			// item in flight belongs to the squashed path
			out_valid <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	// renamed operation, loaded only on acceptance so it holds while stalled
	always_ff @(posedge clock) begin
		if (accept) begin
			out_write <= write;
			out_psrc1 <= psrc1;
			out_psrc2 <= psrc2;
			// no destination fields for stores, branches and rd=x0
			out_pdest <= write ? pdest : '0;
			out_told <= write ? told : '0;
		end
	end

endmodule

`default_nettype wire

// File: logic/free_list.sv
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module free_list (
	input logic clock,
	input logic reset,
	input logic pop,
	input logic push,
	input rename_pkg::phys_reg_t push_reg,
	input logic save,
	input logic restore,
	output rename_pkg::phys_reg_t free_reg,
	output logic empty
);

	localparam int IDX_W = $clog2(`RENAME_FL_SIZE);

	// circular storage of free physical registers
	rename_pkg::phys_reg_t entries [`RENAME_FL_SIZE];

	// head is the next register to hand out, tail the next slot to fill
	rename_pkg::fl_ptr_t head;
	rename_pkg::fl_ptr_t tail;
	// head as captured by the branch checkpoint
	rename_pkg::fl_ptr_t saved_head;
	rename_pkg::fl_ptr_t head_next;

	logic [IDX_W-1:0] head_idx;
	logic [IDX_W-1:0] tail_idx;

	assign head_idx = head[IDX_W-1:0];
	assign tail_idx = tail[IDX_W-1:0];

	// both wrap bits and indices equal
	assign empty = (head == tail);

	// oldest free register, valid whenever not empty
	assign free_reg = entries[head_idx];

	// pop is only issued while not empty, acceptance logic sees to it
	assign head_next = pop ? rename_pkg::fl_ptr_t'(head + 1'b1) : head;

	// head pointer and checkpoint
	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			saved_head <= '0;
		end else if (restore) begin
			// popped entries are still in the array, so moving head back
			// hands the same registers out again
			head <= saved_head;
		end else begin
			head <= head_next;
			// same-cycle pop counts as part of the checkpointed state
			if (save) begin
				saved_head <= head_next;
			end
		end
	end

	// tail side, untouched by restore
	// retired registers are committed state and must survive a squash
	always_ff @(posedge clock) begin
		if (reset) begin
			// phys 32..63 in order, list full with a count of FL_SIZE
			for (int i = 0; i < `RENAME_FL_SIZE; i++) begin
				entries[i] <= rename_pkg::phys_reg_t'(`RENAME_NUM_ARCH_REG + i);
			end
			tail <= rename_pkg::fl_ptr_t'(`RENAME_FL_SIZE);
		end else if (push) begin
			entries[tail_idx] <= push_reg;
			tail <= rename_pkg::fl_ptr_t'(tail + 1'b1);
		end
	end

endmodule

`default_nettype wire

// File: logic/map_table.sv
`default_nettype none
`timescale 1ns/1ns

`include "rename_config.svh"

module map_table (
	input logic clock,
	input logic reset,
	input rename_pkg::arch_reg_t rs1,
	input rename_pkg::arch_reg_t rs2,
	input rename_pkg::arch_reg_t rd,
	input logic alloc,
	input rename_pkg::phys_reg_t new_reg,
	input logic save,
	input logic restore,
	output rename_pkg::phys_reg_t psrc1,
	output rename_pkg::phys_reg_t psrc2,
	output rename_pkg::phys_reg_t told
);

	// live mapping, one physical register per architectural one
	rename_pkg::phys_reg_t map [`RENAME_NUM_ARCH_REG];
	// branch checkpoint copy of the mapping
	rename_pkg::phys_reg_t ckpt [`RENAME_NUM_ARCH_REG];
	// mapping as it stands after this edge, without restore
	rename_pkg::phys_reg_t next_map [`RENAME_NUM_ARCH_REG];

	// lookups see the mapping from before this edge
	// the rename written at this edge shows up for the next instruction
	assign psrc1 = map[rs1];
	assign psrc2 = map[rs2];
	// told is the mapping rd had before the new destination replaces it
	assign told = map[rd];

	always_comb begin
		next_map = map;
		// rd is never x0 here, decode already filtered that out
		if (alloc) begin
			next_map[rd] = new_reg;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity mapping, arch i lives in phys i
			for (int i = 0; i < `RENAME_NUM_ARCH_REG; i++) begin
				map[i] <= rename_pkg::phys_reg_t'(i);
				ckpt[i] <= rename_pkg::phys_reg_t'(i);
			end
		end else if (restore) begin
			// squash all speculative renames since the last save
			// a save in the same cycle is dropped
			map <= ckpt;
		end else begin
			map <= next_map;
			// the copy includes a rename done at the same edge
			if (save) begin
				ckpt <= next_map;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/inst_decode.sv
`default_nettype none
`timescale 1ns/1ns

module inst_decode (
	input logic [31:0] instr,
	output rename_pkg::arch_reg_t rd,
	output rename_pkg::arch_reg_t rs1,
	output rename_pkg::arch_reg_t rs2,
	output logic write
);

	// major opcodes that never write rd
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	logic [6:0] opcode;
	logic no_dest_opcode;

	assign opcode = instr[6:0];

	// register fields sit at fixed positions in every RISC-V format
	// formats without a given field just yield a don't-care index here
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	// stores and branches carry immediate bits where rd would be
	assign no_dest_opcode = (opcode == OPC_STORE) || (opcode == OPC_BRANCH);

	// x0 is hardwired, so a write to it takes no physical register
	// this keeps map entry 0 at phys 0 forever
	always_comb begin
		if (no_dest_opcode) begin
			write = 1'b0;
		end else if (rd == '0) begin
			write = 1'b0;
		end else begin
			write = 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/rename_pkg.sv
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

	// architectural register index, as found in the instruction fields
	typedef logic [$clog2(`RENAME_NUM_ARCH_REG)-1:0] arch_reg_t;

	// physical register index
	// phys 0 stays bound to x0 for good
	typedef logic [$clog2(`RENAME_NUM_PHYS_REG)-1:0] phys_reg_t;

	// free list pointer
	// low bits index the circular array
	// top bit is the wrap flag, flipped each time the pointer wraps around
	// equal pointers mean empty
	// same index with different wrap bits means full
	typedef logic [$clog2(`RENAME_FL_SIZE):0] fl_ptr_t;

endpackage

`default_nettype wire

// File: logic/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// register file sizes for the rename block

// architectural registers seen by software, x0 included
`define RENAME_NUM_ARCH_REG 32

// physical registers behind the map table
`define RENAME_NUM_PHYS_REG 64

// free list capacity
// every physical register not mapped after reset starts out free
`define RENAME_FL_SIZE (`RENAME_NUM_PHYS_REG - `RENAME_NUM_ARCH_REG)

`endif
